/* hdl/pma_pkg.sv */
// Shared types for the physical memory attribute checker.
// Holds the region configuration layout, the access request and the
// check result. Import with a wildcard in the module header.

`default_nettype none

package pma_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths

  // physical address width
  localparam int PLEN = 32;

  ////////////////////////////////////////////////////////////////////////////
  // region attribute encodings

  typedef enum logic [1:0] {
    MEM_EMPTY = 2'd0,
    MEM_MAIN  = 2'd1,
    MEM_IO    = 2'd2
  } pma_mem_type_e;

  typedef enum logic [1:0] {
    AMO_NONE    = 2'd0,
    AMO_SWAP    = 2'd1,
    AMO_LOGICAL = 2'd2,
    AMO_ARITH   = 2'd3
  } pma_amo_e;

  // address matching, same encoding as the pmp A field
  typedef enum logic [1:0] {
    MODE_OFF   = 2'd0,
    MODE_TOR   = 2'd1,
    MODE_NA4   = 2'd2,
    MODE_NAPOT = 2'd3
  } pma_mode_e;

  // 11 bits, sits in the low bits of the config word
  typedef struct packed {
    pma_mem_type_e mem_type;
    pma_amo_e      amo_type;
    logic          r;
    logic          w;
    logic          x;
    logic          c;   // cacheable
    logic          m;   // misaligned access allowed
    pma_mode_e     a;
  } pma_cfg_t;

  ////////////////////////////////////////////////////////////////////////////
  // access request and result

  typedef enum logic [1:0] {
    SIZE_BYTE  = 2'd0,
    SIZE_HWORD = 2'd1,
    SIZE_WORD  = 2'd2,
    SIZE_DWORD = 2'd3
  } pma_size_e;

  typedef struct packed {
    logic            valid;
    logic            instr;
    logic            we;
    logic            lock;
    pma_size_e       size;
    logic [PLEN-1:0] adr;
  } pma_req_t;

  typedef struct packed {
    logic exception;
    logic misaligned;
    logic cacheable;
  } pma_result_t;

endpackage

`default_nettype wire

/* hdl/pma_cfg_regs.sv */
// Wishbone classic register bank for the PMA region table.
// Word index 2k is region k's config word, 2k+1 its address word
// (address bits [PLEN-1:2], right aligned). Ack is one cycle per access.
// Drives the raw address words and a normalized config view.

`timescale 1ns/100ps
`default_nettype none

module pma_cfg_regs
  import pma_pkg::*;
#(
  parameter int PMA_CNT = 8
)
(
  input  wire logic             clk_i,
  input  wire logic             rst_i,

  input  wire logic             wb_cyc_i,
  input  wire logic             wb_stb_i,
  input  wire logic             wb_we_i,
  input  wire logic [7:0]       wb_adr_i,
  input  wire logic [31:0]      wb_dat_i,
  output      logic [31:0]      wb_dat_o,
  output      logic             wb_ack_o,

  output      pma_cfg_t         cfg_o  [PMA_CNT],
  output      logic [PLEN-3:0]  addr_o [PMA_CNT]
);

  // raw register contents
  pma_cfg_t         cfg_q  [PMA_CNT];
  logic [PLEN-3:0]  addr_q [PMA_CNT];

  // decode
  logic             access;
  logic [6:0]       reg_idx;
  logic             sel_addr;
  logic             in_range;
  logic [31:0]      rd_data;

  // new access while no ack is pending
  assign access   = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign reg_idx  = wb_adr_i[7:1];
  assign sel_addr = wb_adr_i[0];
  assign in_range = (int'(reg_idx) < PMA_CNT);

  ////////////////////////////////////////////////////////////////////////////
  // register writes

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      for (int k = 0; k < PMA_CNT; k++)
      begin
        cfg_q[k]  <= '0;
        addr_q[k] <= '0;
      end
    end
    else if (access && wb_we_i && in_range)
    begin
      // only the addressed word changes
      for (int k = 0; k < PMA_CNT; k++)
      begin
        if (reg_idx == 7'(k))
        begin
          if (sel_addr)
            addr_q[k] <= wb_dat_i[PLEN-3:0];
          else
            cfg_q[k]  <= pma_cfg_t'(wb_dat_i[$bits(pma_cfg_t)-1:0]);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read back and ack

  // raw values, zero extended; out of range reads zero
  always_comb
  begin
    rd_data = '0;
    for (int k = 0; k < PMA_CNT; k++)
    begin
      if (in_range && reg_idx == 7'(k))
        rd_data = sel_addr ? 32'(addr_q[k]) : 32'(cfg_q[k]);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      wb_ack_o <= 1'b0;
    else
      wb_ack_o <= access;
  end

  // data register, valid together with ack
  always_ff @(posedge clk_i)
  begin
    if (access)
      wb_dat_o <= rd_data;
  end

  ////////////////////////////////////////////////////////////////////////////
  // normalized view

  for (genvar i = 0; i < PMA_CNT; i++)
  begin : g_norm
    always_comb
    begin
      cfg_o[i] = cfg_q[i];
      // empty region: plain io, no permissions, no amo
      if (cfg_q[i].mem_type == MEM_EMPTY)
      begin
        cfg_o[i].mem_type = MEM_IO;
        cfg_o[i].amo_type = AMO_NONE;
        cfg_o[i].r        = 1'b0;
        cfg_o[i].w        = 1'b0;
        cfg_o[i].x        = 1'b0;
      end
      // cacheable only makes sense for main memory
      cfg_o[i].c = cfg_q[i].c & (cfg_q[i].mem_type == MEM_MAIN);
    end

    assign addr_o[i] = addr_q[i];
  end

endmodule

`default_nettype wire

/* hdl/pma_region_bounds.sv */
// Region bound computation for the PMA checker.
// Per region gives the lower bound (inclusive) and upper bound
// (exclusive) as word addresses, one bit wider than the address word
// so a region can reach the top of the address space. Purely combinational.

`timescale 1ns/100ps
`default_nettype none

module pma_region_bounds
  import pma_pkg::*;
#(
  parameter int PMA_CNT = 8
)
(
  input  wire pma_cfg_t         cfg_i  [PMA_CNT],
  input  wire logic [PLEN-3:0]  addr_i [PMA_CNT],

  output      logic [PLEN-2:0]  lb_o   [PMA_CNT],
  output      logic [PLEN-2:0]  ub_o   [PMA_CNT]
);

  // log2 of the napot region size in words
  // trailing ones n give 2^(n+1) words, capped at the whole space
  function automatic logic [5:0] napot_shift(input logic [PLEN-3:0] word);
    logic [5:0] n;
    logic       run;
    n   = '0;
    run = 1'b1;
    for (int b = 0; b < PLEN-2; b++)
    begin
      if (run && word[b])
        n = n + 6'd1;
      else
        run = 1'b0;
    end
    napot_shift = (n >= 6'(PLEN-3)) ? 6'(PLEN-2) : n + 6'd1;
  endfunction

  for (genvar i = 0; i < PMA_CNT; i++)
  begin : g_region
    logic [5:0]       shift;
    logic [PLEN-2:0]  span;
    logic [PLEN-2:0]  napot_lb;
    logic [PLEN-2:0]  tor_lb;

    // na4 is the single word case
    assign shift    = (cfg_i[i].a == MODE_NA4) ? 6'd0 : napot_shift(addr_i[i]);
    assign span     = (PLEN-1)'(1) << shift;
    assign napot_lb = {1'b0, addr_i[i]} & ~(span - (PLEN-1)'(1));

    // tor lower bound
    if (i == 0)
    begin : g_first
      assign tor_lb = '0;
    end
    else
    begin : g_next
      // after a napot/na4 region use its upper bound, not its raw address
      assign tor_lb = (cfg_i[i-1].a == MODE_TOR) ? {1'b0, addr_i[i-1]} : ub_o[i-1];
    end

    always_comb
    begin
      case (cfg_i[i].a)
        MODE_TOR:
        begin
          lb_o[i] = tor_lb;
          ub_o[i] = {1'b0, addr_i[i]};
        end
        MODE_NA4, MODE_NAPOT:
        begin
          lb_o[i] = napot_lb;
          ub_o[i] = napot_lb + span;
        end
        default:
        begin
          // off: upper bound is the raw word so a following tor
          // still starts at this address, as pmp does
          lb_o[i] = '0;
          ub_o[i] = {1'b0, addr_i[i]};
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/pma_access_match.sv */
// Access range match for the PMA checker.
// Forms the access byte range from address and size and registers, per
// region, whether the whole access lies inside it. Also registers the
// natural alignment check. One register stage, held while stall_i is high.

`timescale 1ns/100ps
`default_nettype none

module pma_access_match
  import pma_pkg::*;
#(
  parameter int PMA_CNT = 8
)
(
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic             stall_i,

  input  wire pma_req_t         req_i,
  input  wire pma_cfg_t         cfg_i [PMA_CNT],
  input  wire logic [PLEN-2:0]  lb_i  [PMA_CNT],
  input  wire logic [PLEN-2:0]  ub_i  [PMA_CNT],

  output      logic [PMA_CNT-1:0] match_all_o,
  output      logic             misaligned_o
);

  // transfer size in bytes
  function automatic logic [3:0] size2bytes(input pma_size_e size);
    case (size)
      SIZE_BYTE:  size2bytes = 4'd1;
      SIZE_HWORD: size2bytes = 4'd2;
      SIZE_WORD:  size2bytes = 4'd4;
      default:    size2bytes = 4'd8;
    endcase
  endfunction

  logic [3:0]         nbytes;
  logic [PLEN:0]      last_byte;
  logic [PLEN-2:0]    acc_lb;
  logic [PLEN-2:0]    acc_last;
  logic [PMA_CNT-1:0] match_all;
  logic               misaligned;

  ////////////////////////////////////////////////////////////////////////////
  // stage 0, access bounds

  assign nbytes    = size2bytes(req_i.size);
  // one extra bit catches a wrap past the top of memory
  assign last_byte = {1'b0, req_i.adr} + (PLEN+1)'(nbytes) - (PLEN+1)'(1);
  assign acc_lb    = {1'b0, req_i.adr[PLEN-1:2]};
  assign acc_last  = last_byte[PLEN:2];

  // first and last word inside [lb, ub)
  for (genvar i = 0; i < PMA_CNT; i++)
  begin : g_match
    assign match_all[i] = (acc_lb >= lb_i[i]) &&
                          (acc_last < ub_i[i]) &&
                          (cfg_i[i].a != MODE_OFF);
  end

  // address not a multiple of the access size
  always_comb
  begin
    case (req_i.size)
      SIZE_BYTE:  misaligned = 1'b0;
      SIZE_HWORD: misaligned = req_i.adr[0];
      SIZE_WORD:  misaligned = |req_i.adr[1:0];
      default:    misaligned = |req_i.adr[2:0];
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 1 registers

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      match_all_o  <= '0;
      misaligned_o <= 1'b0;
    end
    else if (!stall_i)
    begin
      match_all_o  <= match_all;
      misaligned_o <= misaligned;
    end
  end

endmodule

`default_nettype wire

/* hdl/pma_check_ctrl.sv */
// Pipeline control and result decode for the PMA checker.
// Owns the stage 1 valid, the request attributes and a snapshot of the
// region table, all sampled with the match vector. The lowest matching
// region decides exception, misaligned and cacheable.

`timescale 1ns/100ps
`default_nettype none

module pma_check_ctrl
  import pma_pkg::*;
#(
  parameter int PMA_CNT = 8
)
(
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  input  wire logic               stall_i,

  input  wire pma_req_t           req_i,
  input  wire pma_cfg_t           cfg_i [PMA_CNT],
  input  wire logic [PMA_CNT-1:0] match_all_i,
  input  wire logic               misaligned_i,

  output      logic               result_valid_o,
  output      pma_result_t        result_o
);

  localparam int IDX_W = (PMA_CNT > 1) ? $clog2(PMA_CNT) : 1;

  // stage 1 request attributes
  logic             valid_q;
  logic             instr_q;
  logic             we_q;
  logic             lock_q;
  // region table as seen when the request was sampled
  pma_cfg_t         cfg_q [PMA_CNT];

  logic [IDX_W-1:0] sel_idx;
  logic             any_match;
  pma_cfg_t         sel_cfg;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1 registers

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      valid_q <= 1'b0;
      instr_q <= 1'b0;
      we_q    <= 1'b0;
      lock_q  <= 1'b0;
    end
    else if (!stall_i)
    begin
      valid_q <= req_i.valid;
      instr_q <= req_i.instr;
      we_q    <= req_i.we;
      lock_q  <= req_i.lock;
    end
  end

  // later config writes do not disturb an item already in stage 1
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      for (int k = 0; k < PMA_CNT; k++)
        cfg_q[k] <= cfg_i[k];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // priority select, lowest index wins

  always_comb
  begin
    sel_idx = '0;
    for (int k = PMA_CNT-1; k >= 0; k--)
    begin
      if (match_all_i[k])
        sel_idx = IDX_W'(k);
    end
  end

  assign any_match = |match_all_i;
  assign sel_cfg   = cfg_q[sel_idx];

  ////////////////////////////////////////////////////////////////////////////
  // result decode

  always_comb
  begin
    result_o.exception  = ~any_match                         |
                          ( instr_q & ~sel_cfg.x)            |
                          ( we_q    & ~sel_cfg.w)            |
                          (~we_q    & ~sel_cfg.r)            |
                          ( lock_q  & (sel_cfg.amo_type == AMO_NONE));
    // no match: report alignment as is
    result_o.misaligned = misaligned_i & ~(any_match & sel_cfg.m);
    result_o.cacheable  = any_match & sel_cfg.c;
  end

  assign result_valid_o = valid_q;

endmodule

`default_nettype wire

/* hdl/pma_checker.sv */
// PMA checker top level.
// Region table over a Wishbone classic slave, two stage access check.
// Result is valid one clock after an unstalled valid request;
// stall_i freezes the pipeline and holds the result.

`timescale 1ns/100ps
`default_nettype none

module pma_checker
  import pma_pkg::*;
#(
  parameter int PMA_CNT = 8
)
(
  input  wire logic         clk_i,
  input  wire logic         rst_i,
  input  wire logic         stall_i,

  // access request and result
  input  wire pma_req_t     req_i,
  output      logic         result_valid_o,
  output      pma_result_t  result_o,

  // region table, wishbone classic slave
  input  wire logic         wb_cyc_i,
  input  wire logic         wb_stb_i,
  input  wire logic         wb_we_i,
  input  wire logic [7:0]   wb_adr_i,
  input  wire logic [31:0]  wb_dat_i,
  output      logic [31:0]  wb_dat_o,
  output      logic         wb_ack_o
);

  pma_cfg_t           cfg       [PMA_CNT];
  logic [PLEN-3:0]    addr      [PMA_CNT];
  logic [PLEN-2:0]    lb        [PMA_CNT];
  logic [PLEN-2:0]    ub        [PMA_CNT];
  logic [PMA_CNT-1:0] match_all;
  logic               misaligned;

  pma_cfg_regs #(.PMA_CNT(PMA_CNT)) u_cfg_regs (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .cfg_o    (cfg),
    .addr_o   (addr)
  );

  // stage 0, region bounds
  pma_region_bounds #(.PMA_CNT(PMA_CNT)) u_bounds (
    .cfg_i  (cfg),
    .addr_i (addr),
    .lb_o   (lb),
    .ub_o   (ub)
  );

  // stage 0 to 1, per region full match
  pma_access_match #(.PMA_CNT(PMA_CNT)) u_match (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .stall_i      (stall_i),
    .req_i        (req_i),
    .cfg_i        (cfg),
    .lb_i         (lb),
    .ub_i         (ub),
    .match_all_o  (match_all),
    .misaligned_o (misaligned)
  );

  pma_check_ctrl #(.PMA_CNT(PMA_CNT)) u_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .stall_i        (stall_i),
    .req_i          (req_i),
    .cfg_i          (cfg),
    .match_all_i    (match_all),
    .misaligned_i   (misaligned),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

endmodule

`default_nettype wire

/* test/pma_ref.svh */
// Reference model for the PMA checker testbench.
// Bounds are byte addresses in 64 bits so nothing wraps.
// Included inside the testbench module; reads its shadow tables
// sh_cfg and sh_addr and its REGIONS count.

`ifndef PMA_REF_SVH
`define PMA_REF_SVH

// na4 covers four bytes
// napot with t trailing ones covers 2^(t+3) bytes, at most 4 GiB
function automatic void napot_range(input logic [29:0] word, input pma_mode_e mode,
                                    output longint unsigned lo, output longint unsigned hi);
  longint unsigned sz;
  int              t;
  t  = 0;
  sz = 64'd4;
  if (mode == MODE_NAPOT)
  begin
    while (t < 30 && word[t])
      t++;
    sz = 64'd8 << t;
    if (sz > 64'h1_0000_0000)
      sz = 64'h1_0000_0000;
  end
  lo = {32'd0, word, 2'b00} & ~(sz - 64'd1);
  hi = lo + sz;
endfunction

// byte range [lo, hi) of region k
function automatic void region_range(input int k, output longint unsigned lo,
                                     output longint unsigned hi);
  pma_cfg_t        cfg;
  pma_cfg_t        prev;
  longint unsigned plo;
  longint unsigned phi;
  cfg = pma_cfg_t'(sh_cfg[k]);
  lo  = 64'd0;
  hi  = {32'd0, sh_addr[k], 2'b00};
  if (cfg.a == MODE_NA4 || cfg.a == MODE_NAPOT)
    napot_range(sh_addr[k], cfg.a, lo, hi);
  else if (cfg.a == MODE_TOR && k > 0)
  begin
    // tor starts where the region below ends
    prev = pma_cfg_t'(sh_cfg[k-1]);
    if (prev.a == MODE_NA4 || prev.a == MODE_NAPOT)
    begin
      napot_range(sh_addr[k-1], prev.a, plo, phi);
      lo = phi;
    end
    else
      lo = {32'd0, sh_addr[k-1], 2'b00};
  end
endfunction

// expected result of one access against the shadow table
function automatic pma_result_t expected_result(input pma_req_t req);
  pma_result_t     res;
  pma_cfg_t        cfg;
  longint unsigned lo;
  longint unsigned hi;
  longint unsigned a_lo;
  longint unsigned a_hi;
  int              hit;
  a_lo = 64'(req.adr);
  a_hi = a_lo + (64'd1 << req.size);
  hit  = -1;
  // scan downwards, the lowest full match is kept
  for (int k = REGIONS-1; k >= 0; k--)
  begin
    cfg = pma_cfg_t'(sh_cfg[k]);
    region_range(k, lo, hi);
    if (cfg.a != MODE_OFF && a_lo >= lo && a_hi <= hi)
      hit = k;
  end
  res.misaligned = (a_lo % (64'd1 << req.size)) != 64'd0;
  if (hit < 0)
  begin
    res.exception = 1'b1;
    res.cacheable = 1'b0;
    return res;
  end
  cfg = pma_cfg_t'(sh_cfg[hit]);
  // an empty region grants nothing
  res.exception  = (req.instr && !cfg.x) || (req.we && !cfg.w) ||
                   (!req.we && !cfg.r) ||
                   (req.lock && cfg.amo_type == AMO_NONE) ||
                   (cfg.mem_type == MEM_EMPTY);
  res.misaligned = res.misaligned && !cfg.m;
  res.cacheable  = cfg.c && (cfg.mem_type == MEM_MAIN);
  return res;
endfunction

`endif

/* test/pma_tb.sv */
// Testbench for the PMA checker.
// Programs the region table over Wishbone, sweeps directed probes and a
// random request stream with random stall, and compares every result
// with the reference model. Inputs change 1 ns after the rising edge,
// results are sampled on the falling edge.

`timescale 1ns/100ps
`default_nettype none

module pma_tb
  import pma_pkg::*;
();

  localparam int REGIONS = 8;
  localparam int TIMEOUT = 100;
  localparam int NPROBE  = 21;

  // probe addresses around the directed region edges
  localparam logic [31:0] PROBE_ADR [NPROBE] = '{
    32'h0ffc, 32'h1000, 32'h1002, 32'h1004, 32'h20f8, 32'h20fc, 32'h20fe,
    32'h2100, 32'h2ffe, 32'h3000, 32'h33fc, 32'h4010, 32'h403c, 32'h4800,
    32'h5000, 32'h5ffc, 32'h8001, 32'h8006, 32'h9001, 32'h9005, 32'ha001
  };

  logic         clk_i;
  logic         rst_i;
  logic         stall_i;
  pma_req_t     req_i;
  logic         result_valid_o;
  pma_result_t  result_o;
  logic         wb_cyc_i;
  logic         wb_stb_i;
  logic         wb_we_i;
  logic [7:0]   wb_adr_i;
  logic [31:0]  wb_dat_i;
  logic [31:0]  wb_dat_o;
  logic         wb_ack_o;

  // shadow of the region table, raw as written
  logic [10:0]  sh_cfg  [REGIONS];
  logic [29:0]  sh_addr [REGIONS];
  // expected results of accepted requests, oldest first
  pma_result_t  exp_q [$];

  `include "pma_ref.svh"

  pma_checker #(.PMA_CNT(REGIONS)) u_dut (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .stall_i        (stall_i),
    .req_i          (req_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever
      #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want)
    begin
      $display("ERROR %s got 0x%08h expected 0x%08h", name, got, want);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "run aborted");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // wishbone

  // one classic cycle ending 1 ns after the ack edge
  task automatic wb_cycle(input logic we, input logic [7:0] idx, input logic [31:0] data);
    int n;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = idx;
    wb_dat_i = data;
    n = 0;
    do
    begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > TIMEOUT)
        abort_run("wishbone cycle got no ack");
    end
    while (wb_ack_o !== 1'b1);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [7:0] idx, input logic [31:0] data);
    int k;
    k = int'(idx) / 2;
    wb_cycle(1'b1, idx, data);
    if (k < REGIONS && idx[0])
      sh_addr[k] = data[29:0];
    else if (k < REGIONS)
      sh_cfg[k] = data[10:0];
  endtask

  task automatic wb_read_check(input logic [7:0] idx);
    logic [31:0] want;
    int          k;
    k    = int'(idx) / 2;
    want = 32'd0;
    if (k < REGIONS)
      want = idx[0] ? {2'd0, sh_addr[k]} : {21'd0, sh_cfg[k]};
    wb_cycle(1'b0, idx, 32'd0);
    check($sformatf("wb_dat_o[%0d]", idx), wb_dat_o, want);
  endtask

  task automatic clear_table();
    for (int k = 0; k < 2*REGIONS; k++)
      wb_write(8'(k), 32'd0);
  endtask

  function automatic logic [31:0] region_cfg(input pma_mem_type_e mem, input pma_amo_e amo,
                                             input logic [2:0] rwx, input logic c,
                                             input logic m, input pma_mode_e a);
    pma_cfg_t cfg;
    cfg.mem_type        = mem;
    cfg.amo_type        = amo;
    {cfg.r, cfg.w, cfg.x} = rwx;
    cfg.c               = c;
    cfg.m               = m;
    cfg.a               = a;
    return {21'd0, cfg};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // requests

  // one cycle of request and stall with the expected result queued if accepted
  task automatic send_req(input pma_req_t req, input logic stall);
    req_i   = req;
    stall_i = stall;
    if (req.valid && !stall)
      exp_q.push_back(expected_result(req));
    @(posedge clk_i);
    #1;
  endtask

  // every probe with every size as read, write, fetch and locked write
  task automatic probe_sweep();
    pma_req_t req;
    for (int p = 0; p < NPROBE; p++)
      for (int s = 0; s < 4; s++)
        for (int kind = 0; kind < 4; kind++)
        begin
          req.valid = 1'b1;
          req.instr = (kind == 2);
          req.we    = (kind == 1) || (kind == 3);
          req.lock  = (kind == 3);
          req.size  = pma_size_e'(2'(s));
          req.adr   = PROBE_ADR[p];
          send_req(req, 1'b0);
        end
  endtask

  // idle the request side and wait for every result
  task automatic drain();
    int n;
    req_i   = '0;
    stall_i = 1'b0;
    n = 0;
    while (exp_q.size() != 0)
    begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > TIMEOUT)
        abort_run("results still pending after the drain timeout");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare

  initial
  begin : compare
    logic        held_stall;
    logic        held_valid;
    pma_result_t held_res;
    pma_result_t want;
    held_stall = 1'b0;
    held_valid = 1'b0;
    held_res   = '0;
    forever
    begin
      @(negedge clk_i);
      if (held_stall)
      begin
        // stalled edge so outputs hold
        check("result_valid_o", 32'(result_valid_o), 32'(held_valid));
        check("result_o", 32'(result_o), 32'(held_res));
      end
      else if (result_valid_o === 1'b1)
      begin
        if (exp_q.size() == 0)
          abort_run("result valid with no request pending");
        want = exp_q.pop_front();
        check("result_o.exception", 32'(result_o.exception), 32'(want.exception));
        check("result_o.misaligned", 32'(result_o.misaligned), 32'(want.misaligned));
        check("result_o.cacheable", 32'(result_o.cacheable), 32'(want.cacheable));
      end
      held_stall = stall_i;
      held_valid = result_valid_o;
      held_res   = result_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  initial
  begin : stimulus
    pma_req_t req;
    void'($urandom(79));
    rst_i    = 1'b1;
    stall_i  = 1'b0;
    req_i    = '0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = 8'd0;
    wb_dat_i = 32'd0;
    for (int k = 0; k < REGIONS; k++)
    begin
      sh_cfg[k]  = '0;
      sh_addr[k] = '0;
    end
    repeat (16) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // reset state with every region off so every access faults
    for (int k = 0; k < 2*REGIONS; k++)
      wb_read_check(8'(k));
    wb_read_check(8'd16);
    wb_read_check(8'd255);
    probe_sweep();
    drain();

    // register read back and dropped out of range writes
    for (int k = 0; k < 2*REGIONS; k++)
      wb_write(8'(k), $urandom);
    wb_write(8'd200, 32'hffff_ffff);
    for (int k = 0; k < 2*REGIONS; k++)
      wb_read_check(8'(k));
    wb_read_check(8'd200);

    // na4, napot, tor after napot, tor after tor
    clear_table();
    wb_write(8'd0, region_cfg(MEM_MAIN, AMO_ARITH, 3'b111, 1'b1, 1'b0, MODE_NA4));
    wb_write(8'd1, 32'h0000_0400);
    wb_write(8'd2, region_cfg(MEM_MAIN, AMO_ARITH, 3'b111, 1'b0, 1'b0, MODE_NAPOT));
    wb_write(8'd3, 32'h0000_081f);
    wb_write(8'd4, region_cfg(MEM_IO, AMO_SWAP, 3'b110, 1'b0, 1'b0, MODE_TOR));
    wb_write(8'd5, 32'h0000_0c00);
    wb_write(8'd6, region_cfg(MEM_MAIN, AMO_LOGICAL, 3'b101, 1'b1, 1'b0, MODE_TOR));
    wb_write(8'd7, 32'h0000_0d00);
    probe_sweep();
    drain();

    // read write io without amo over main, and an empty region
    clear_table();
    wb_write(8'd0, region_cfg(MEM_IO, AMO_NONE, 3'b110, 1'b1, 1'b0, MODE_NAPOT));
    wb_write(8'd1, 32'h0000_1007);
    wb_write(8'd2, region_cfg(MEM_MAIN, AMO_ARITH, 3'b111, 1'b1, 1'b0, MODE_NAPOT));
    wb_write(8'd3, 32'h0000_11ff);
    wb_write(8'd4, region_cfg(MEM_EMPTY, AMO_SWAP, 3'b111, 1'b1, 1'b1, MODE_NAPOT));
    wb_write(8'd5, 32'h0000_15ff);
    probe_sweep();
    drain();

    // misaligned allowed at 0x8000, not at 0x9000
    clear_table();
    wb_write(8'd0, region_cfg(MEM_MAIN, AMO_ARITH, 3'b111, 1'b0, 1'b1, MODE_NAPOT));
    wb_write(8'd1, 32'h0000_201f);
    wb_write(8'd2, region_cfg(MEM_MAIN, AMO_ARITH, 3'b111, 1'b0, 1'b0, MODE_NAPOT));
    wb_write(8'd3, 32'h0000_241f);
    probe_sweep();
    drain();

    // random tables in the low 4 KiB and a random stream with stall
    for (int round = 0; round < 20; round++)
    begin
      for (int k = 0; k < 2*REGIONS; k++)
        wb_write(8'(k), (k % 2 == 0) ? $urandom : $urandom_range(0, 'h3ff));
      for (int j = 0; j < 150; j++)
      begin
        req.valid = ($urandom_range(0, 7) != 0);
        req.instr = 1'($urandom_range(0, 1));
        req.we    = 1'($urandom_range(0, 1));
        req.lock  = 1'($urandom_range(0, 1));
        req.size  = pma_size_e'(2'($urandom_range(0, 3)));
        req.adr   = $urandom_range(0, 'h1100);
        send_req(req, $urandom_range(0, 3) == 0);
      end
      drain();
    end

    if (exp_q.size() == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+test
hdl/pma_pkg.sv
hdl/pma_cfg_regs.sv
hdl/pma_region_bounds.sv
hdl/pma_access_match.sv
hdl/pma_check_ctrl.sv
hdl/pma_checker.sv
test/pma_tb.sv

/* Makefile */
# Verilator build and run of the PMA checker testbench.
# Any variable can be set on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= pma_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, a missing pass line fails the target
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
